//--- verilog.f
common/ex_pkg.sv
logic/ex_alu.sv
multdiv/ex_multdiv_iter.sv
logic/ex_block.sv
dv/ex_block_props.sv
dv/ex_block_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execution stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ex_block_tb -Mdir obj_dir -o ex_block_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ex_block_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- dv/ex_block_tb.sv
/*
  Table-driven testbench of ex_block with BranchTargetAlu set.
  Directed rows carry hand-derived results; random multiply/divide rows use a
  64-bit reference model. Immediate and bound assertions need Verilator --assert.
*/
`timescale 1ns/1ns

module ex_block_tb;

  typedef enum logic [1:0] {
    ROW_ALU, ROW_MD, ROW_BT
  } row_kind_e;

  // BT rows keep pc in a and the immediate in b
  typedef struct packed {
    row_kind_e          kind;
    logic [4:0]         op;
    ex_pkg::xlen_word_t a;
    ex_pkg::xlen_word_t b;
    ex_pkg::xlen_word_t exp_res;
    logic               exp_br;
  } row_t;

  logic               clk_i;
  logic               rst_n_i;
  ex_pkg::alu_req_t   alu_req_i;
  ex_pkg::md_req_t    md_req_i;
  logic               multdiv_en_i;
  ex_pkg::bt_req_t    bt_req_i;
  ex_pkg::xlen_word_t alu_adder_result_o;
  ex_pkg::xlen_word_t result_o;
  ex_pkg::xlen_word_t jump_target_o;
  logic               branch_decision_o;
  logic               ex_valid_o;

  row_t        rows[$];
  int unsigned cycle_limit;
  int unsigned cycles;
  int unsigned tests;
  int unsigned errors;

  ex_block #(
    .BranchTargetAlu(1'b1)
  ) uut (.*);

  bind ex_block ex_block_props props_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .multdiv_en_i (multdiv_en_i),
    .ex_valid_o   (ex_valid_o),
    .result_o     (result_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////////////////////////

  // Truncating division with the RISC-V results for a zero divisor and overflow
  function automatic ex_pkg::xlen_word_t md_reference(input ex_pkg::md_op_e op,
                                                     input ex_pkg::xlen_word_t a,
                                                     input ex_pkg::xlen_word_t b);
    logic [63:0]        sa;
    logic [63:0]        sb;
    logic [63:0]        prod;
    logic signed [31:0] qa;
    logic signed [31:0] qb;
    logic signed [31:0] quo;
    logic signed [31:0] rem;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    qa  = a;
    qb  = b;
    // Signed quotient and remainder
    if (b == 0) begin
      quo = '1;
      rem = a;
    end else if ((a == 32'h8000_0000) && (b == 32'hFFFF_FFFF)) begin
      quo = a;
      rem = '0;
    end else begin
      quo = qa / qb;
      rem = qa % qb;
    end
    case (op)
      ex_pkg::MD_MUL:    prod = sa * sb;
      ex_pkg::MD_MULH:   prod = sa * sb;
      ex_pkg::MD_MULHSU: prod = sa * {32'd0, b};
      default:           prod = {32'd0, a} * {32'd0, b};
    endcase
    case (op)
      ex_pkg::MD_MUL:  return prod[31:0];
      ex_pkg::MD_DIV:  return quo;
      ex_pkg::MD_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
      ex_pkg::MD_REM:  return rem;
      ex_pkg::MD_REMU: return (b == 0) ? a : a % b;
      default:         return prod[63:32];
    endcase
  endfunction

  task automatic add_alu(input ex_pkg::alu_op_e op, input ex_pkg::xlen_word_t a,
                         input ex_pkg::xlen_word_t b, input ex_pkg::xlen_word_t res,
                         input logic br);
    rows.push_back('{ROW_ALU, op, a, b, res, br});
  endtask

  task automatic add_md(input ex_pkg::md_op_e op, input ex_pkg::xlen_word_t a,
                        input ex_pkg::xlen_word_t b, input ex_pkg::xlen_word_t res);
    rows.push_back('{ROW_MD, {2'b00, op}, a, b, res, 1'bx});
  endtask

  task automatic add_bt(input ex_pkg::xlen_word_t pc, input ex_pkg::bt_imm_t imm,
                        input ex_pkg::xlen_word_t target);
    rows.push_back('{ROW_BT, 5'd0, pc, {20'd0, imm}, target, 1'bx});
  endtask

  task automatic build_table();
    logic [2:0]         op_bits;
    ex_pkg::xlen_word_t a;
    ex_pkg::xlen_word_t b;
    add_alu(ex_pkg::ALU_ADD,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'bx);
    add_alu(ex_pkg::ALU_SUB,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 1'bx);
    add_alu(ex_pkg::ALU_XOR,  32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00, 1'bx);
    add_alu(ex_pkg::ALU_OR,   32'hF0F0_0000, 32'h0000_0F0F, 32'hF0F0_0F0F, 1'bx);
    add_alu(ex_pkg::ALU_AND,  32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'h00F0_00F0, 1'bx);
    add_alu(ex_pkg::ALU_SLL,  32'h8000_0001, 32'h0000_0000, 32'h8000_0001, 1'bx);
    // Only the low five bits of b count
    add_alu(ex_pkg::ALU_SLL,  32'h0000_0001, 32'h0000_003F, 32'h8000_0000, 1'bx);
    add_alu(ex_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_001F, 32'h0000_0001, 1'bx);
    add_alu(ex_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_001F, 32'hFFFF_FFFF, 1'bx);
    add_alu(ex_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 1'bx);
    add_alu(ex_pkg::ALU_SLT,  32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1);
    add_alu(ex_pkg::ALU_SLTU, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0000, 1'b0);
    add_alu(ex_pkg::ALU_EQ,   32'h1234_5678, 32'h1234_5678, 32'h0000_0001, 1'b1);
    add_alu(ex_pkg::ALU_NE,   32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_alu(ex_pkg::ALU_LT,   32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 1'b1);
    add_alu(ex_pkg::ALU_GE,   32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_alu(ex_pkg::ALU_LTU,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_alu(ex_pkg::ALU_GEU,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 1'b1);
    add_md(ex_pkg::MD_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_md(ex_pkg::MD_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_md(ex_pkg::MD_MULH,   32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFF);
    add_md(ex_pkg::MD_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_md(ex_pkg::MD_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
    add_md(ex_pkg::MD_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_md(ex_pkg::MD_DIV,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD);
    add_md(ex_pkg::MD_REM,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF);
    add_md(ex_pkg::MD_DIVU,   32'hFFFF_FFF9, 32'h0000_0002, 32'h7FFF_FFFC);
    add_md(ex_pkg::MD_REMU,   32'hFFFF_FFF9, 32'h0000_0002, 32'h0000_0001);
    add_md(ex_pkg::MD_DIV,    32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF);
    add_md(ex_pkg::MD_REM,    32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_md(ex_pkg::MD_DIVU,   32'h8000_0001, 32'h0000_0000, 32'hFFFF_FFFF);
    add_md(ex_pkg::MD_REMU,   32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
    add_md(ex_pkg::MD_DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_md(ex_pkg::MD_REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_alu(ex_pkg::ALU_ADD,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C, 1'bx);
    add_bt(32'h0000_1000, 12'h010, 32'h0000_1020);
    add_bt(32'h0000_1000, 12'hFFF, 32'h0000_0FFE);
    add_bt(32'h0000_0100, 12'h800, 32'hFFFF_F100);
    add_bt(32'hFFFF_FFF0, 12'h7FF, 32'h0000_0FEE);
    // Random rows run back to back
    for (int i = 0; i < 20; i++) begin
      op_bits = 3'($urandom % 8);
      a       = $urandom;
      b       = $urandom;
      if ($urandom % 4 == 0) begin
        b = b & 32'h0000_0007;
      end
      add_md(ex_pkg::md_op_e'(op_bits), a, b, md_reference(ex_pkg::md_op_e'(op_bits), a, b));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input int unsigned idx, input string what,
                                 input ex_pkg::xlen_word_t got,
                                 input ex_pkg::xlen_word_t exp);
    errors++;
    $display("** Error @ %0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
  endtask

  task automatic check_idle_valid(input string when);
    tests++;
    assert (ex_valid_o === 1'b1) else begin
      errors++;
      $display("** Error @ %0t: ex_valid_o is %b %s, expected 1", $time, ex_valid_o, when);
    end
    $display("valid %s: %s", when, (ex_valid_o === 1'b1) ? "pass" : "fail");
  endtask

  // Starts and ends on a falling edge
  task automatic run_row(input row_t r, input int unsigned idx);
    int unsigned waited;
    int unsigned errors_before;
    errors_before = errors;
    alu_req_i     = '{ex_pkg::ALU_ADD, 32'h0, 32'h0};
    md_req_i      = '{ex_pkg::md_op_e'(r.op[2:0]), r.a, r.b};
    multdiv_en_i  = (r.kind == ROW_MD);
    bt_req_i      = '{ex_pkg::JT_ALU, 12'h100, 32'h0000_4000};
    case (r.kind)
      ROW_ALU: alu_req_i = '{ex_pkg::alu_op_e'(r.op), r.a, r.b};
      ROW_BT:  bt_req_i  = '{ex_pkg::JT_BT, r.b[11:0], r.a};
      default: ;
    endcase
    @(negedge clk_i);
    waited = 1;
    while (r.kind == ROW_MD && !ex_valid_o) begin
      @(negedge clk_i);
      waited++;
    end
    if (r.kind == ROW_BT) begin
      assert (jump_target_o === r.exp_res)
        else report_mismatch(idx, "jump_target_o", jump_target_o, r.exp_res);
    end else begin
      assert (result_o === r.exp_res)
        else report_mismatch(idx, "result_o", result_o, r.exp_res);
    end
    if (r.kind == ROW_ALU) begin
      if (r.exp_br !== 1'bx) begin
        assert (branch_decision_o === r.exp_br)
          else report_mismatch(idx, "branch_decision_o",
                               ex_pkg::xlen_word_t'(branch_decision_o),
                               ex_pkg::xlen_word_t'(r.exp_br));
      end
      // Add and subtract show the address adder directly
      if (r.op inside {ex_pkg::ALU_ADD, ex_pkg::ALU_SUB}) begin
        assert (alu_adder_result_o === r.exp_res)
          else report_mismatch(idx, "alu_adder_result_o", alu_adder_result_o, r.exp_res);
      end
      assert (ex_valid_o === 1'b1) else begin
        errors++;
        $display("** Error @ %0t: row %0d ex_valid_o is %b, expected 1", $time, idx, ex_valid_o);
      end
      // Under JT_ALU the jump target is the adder result
      assert (jump_target_o === alu_adder_result_o)
        else report_mismatch(idx, "jump_target_o", jump_target_o, alu_adder_result_o);
    end
    if (r.kind == ROW_MD) begin
      assert (waited >= 2) else begin
        errors++;
        $display("Row %0d: ex_valid_o was already high one cycle after the start", idx);
      end
    end
    tests++;
    $display("row %0d %s op %0d: %s", idx, r.kind.name(), r.op,
             (errors == errors_before) ? "pass" : "fail");
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    alu_req_i    = '0;
    md_req_i     = '0;
    multdiv_en_i = 1'b0;
    bt_req_i     = '0;
    cycles       = 0;
    tests        = 0;
    errors       = 0;
    void'($urandom(32'he9c8_288f));
    build_table();
    // Worst case per row plus the reset cycles
    cycle_limit = rows.size() * (ex_pkg::MD_MAX_LATENCY + 4) + 10;

    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle_valid("after reset");

    for (int i = 0; i < rows.size(); i++) begin
      run_row(rows[i], i);
    end

    multdiv_en_i = 1'b0;
    @(negedge clk_i);
    check_idle_valid("after last operation");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- dv/ex_block_props.sv
/*
  Timing properties of the execution stage, bound into ex_block.
  Latency counts clock edges with multdiv_en_i high and ex_valid_o still low.
*/
`timescale 1ns/1ns

module ex_block_props (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               multdiv_en_i,
  input logic               ex_valid_o,
  input ex_pkg::xlen_word_t result_o
);

  logic [7:0] wait_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !multdiv_en_i || ex_valid_o) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_q + 8'd1;
    end
  end

  valid_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !multdiv_en_i |-> ex_valid_o)
    else $error("ex_valid_o low while multdiv_en_i is low");

  latency_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    32'(wait_cnt_q) <= ex_pkg::MD_MAX_LATENCY)
    else $error("multiply/divide result later than MD_MAX_LATENCY cycles");

  result_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ex_valid_o |-> !$isunknown(result_o))
    else $error("result_o has unknown bits while ex_valid_o is high");

endmodule

//--- logic/ex_block.sv
/*
  Execution stage of the RV32 core, ALU plus iterative multiply/divide unit.
  Outputs are combinational while multdiv_en_i is low; operands must be held
  until ex_valid_o when multdiv_en_i is high. No pipeline registers at the ports.
*/
`timescale 1ns/1ns

module ex_block #(
  parameter bit BranchTargetAlu = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ex_pkg::alu_req_t   alu_req_i,
  input  ex_pkg::md_req_t    md_req_i,
  input  logic               multdiv_en_i,
  input  ex_pkg::bt_req_t    bt_req_i,
  output ex_pkg::xlen_word_t alu_adder_result_o,
  output ex_pkg::xlen_word_t result_o,
  output ex_pkg::xlen_word_t jump_target_o,
  output logic               branch_decision_o,
  output logic               ex_valid_o
);

  ex_pkg::xlen_word_t  alu_result;
  ex_pkg::xlen_word_t  md_result;
  ex_pkg::md_operand_t md_alu_a;
  ex_pkg::md_operand_t md_alu_b;
  logic                md_alu_sel;
  ex_pkg::adder_ext_t  alu_adder_ext;
  logic                alu_is_equal;
  logic                md_valid;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .alu_req_i           (alu_req_i),
    .md_alu_a_i          (md_alu_a),
    .md_alu_b_i          (md_alu_b),
    .md_alu_sel_i        (md_alu_sel),
    .adder_result_o      (alu_adder_result_o),
    .adder_result_ext_o  (alu_adder_ext),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o),
    .is_equal_o          (alu_is_equal)
  );

  ////////////////////////////////////////////////////////////
  // Multiply/divide
  ////////////////////////////////////////////////////////////

  ex_multdiv_iter multdiv_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .en_i            (multdiv_en_i),
    .md_req_i        (md_req_i),
    .alu_adder_ext_i (alu_adder_ext),
    .alu_is_equal_i  (alu_is_equal),
    .alu_a_o         (md_alu_a),
    .alu_b_o         (md_alu_b),
    .alu_sel_o       (md_alu_sel),
    .valid_o         (md_valid),
    .result_o        (md_result)
  );

  assign result_o   = multdiv_en_i ? md_result : alu_result;
  // ALU results are ready in the same cycle
  assign ex_valid_o = multdiv_en_i ? md_valid : 1'b1;

  ////////////////////////////////////////////////////////////
  // Jump target
  ////////////////////////////////////////////////////////////

  if (BranchTargetAlu) begin : g_bt_alu
    ex_pkg::xlen_word_t bt_offset;
    ex_pkg::xlen_word_t bt_target;

    // Immediate is in halfwords
    assign bt_offset = {{(ex_pkg::XLEN - 13){bt_req_i.imm[11]}}, bt_req_i.imm, 1'b0};
    assign bt_target = bt_req_i.pc + bt_offset;

    assign jump_target_o = (bt_req_i.jt_sel == ex_pkg::JT_ALU) ? alu_adder_result_o : bt_target;
  end else begin : g_no_bt_alu
    // Jumps and branches both use the main adder
    assign jump_target_o = alu_adder_result_o;
  end

endmodule

//--- multdiv/ex_multdiv_iter.sv
/*
  Iterative multiply/divide unit, one bit per cycle through the ALU adder.
  md_req_i must stay unchanged while en_i is high; dropping en_i aborts the operation.
  valid_o is high for exactly one cycle per operation.
*/
`timescale 1ns/1ns

module ex_multdiv_iter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                en_i,
  input  ex_pkg::md_req_t     md_req_i,
  input  ex_pkg::adder_ext_t  alu_adder_ext_i,
  input  logic                alu_is_equal_i,
  output ex_pkg::md_operand_t alu_a_o,
  output ex_pkg::md_operand_t alu_b_o,
  output logic                alu_sel_o,
  output logic                valid_o,
  output ex_pkg::xlen_word_t  result_o
);

  ex_pkg::md_state_e   state_q;
  ex_pkg::md_state_e   state_d;
  ex_pkg::md_cnt_t     cnt_q;

  // op_q holds the multiplicand or the divisor, lo_q the multiplier or dividend
  ex_pkg::xlen_word_t  op_q;
  ex_pkg::xlen_word_t  acc_q;
  ex_pkg::xlen_word_t  lo_q;
  ex_pkg::xlen_word_t  result_q;
  logic                neg_q;

  logic                is_div;
  logic                is_rem;
  logic                a_neg;
  logic                b_neg;
  ex_pkg::xlen_word_t  abs_a;
  ex_pkg::xlen_word_t  abs_b;
  ex_pkg::md_operand_t sum;
  logic                div_ok;
  ex_pkg::xlen_word_t  acc_d;
  ex_pkg::xlen_word_t  lo_d;
  logic [2*ex_pkg::XLEN-1:0] fix_mag;
  logic [2*ex_pkg::XLEN-1:0] fix_val;
  ex_pkg::xlen_word_t  fix_result;

  ////////////////////////////////////////////////////////////
  // Operation decode and operand magnitudes
  ////////////////////////////////////////////////////////////

  assign is_div = md_req_i.op inside {ex_pkg::MD_DIV, ex_pkg::MD_DIVU,
                                      ex_pkg::MD_REM, ex_pkg::MD_REMU};
  assign is_rem = md_req_i.op inside {ex_pkg::MD_REM, ex_pkg::MD_REMU};

  // MUL keeps unsigned operands since its low half is sign independent
  assign a_neg = md_req_i.operand_a[ex_pkg::XLEN-1] &
                 (md_req_i.op inside {ex_pkg::MD_MULH, ex_pkg::MD_MULHSU,
                                      ex_pkg::MD_DIV, ex_pkg::MD_REM});
  assign b_neg = md_req_i.operand_b[ex_pkg::XLEN-1] &
                 (md_req_i.op inside {ex_pkg::MD_MULH, ex_pkg::MD_DIV, ex_pkg::MD_REM});

  assign abs_a = a_neg ? -md_req_i.operand_a : md_req_i.operand_a;
  assign abs_b = b_neg ? -md_req_i.operand_b : md_req_i.operand_b;

  ////////////////////////////////////////////////////////////
  // Adder operands
  ////////////////////////////////////////////////////////////

  assign alu_sel_o = (state_q == ex_pkg::MD_ABS) || (state_q == ex_pkg::MD_ITER);

  always_comb begin
    alu_a_o = '0;
    alu_b_o = '0;
    case (state_q)
      // Pass the divisor through so the ALU flags a zero
      ex_pkg::MD_ABS: alu_b_o = {1'b0, md_req_i.operand_b};
      ex_pkg::MD_ITER: begin
        if (is_div) begin
          alu_a_o = {1'b0, acc_q[ex_pkg::XLEN-2:0], lo_q[ex_pkg::XLEN-1]};
          alu_b_o = {1'b1, ~op_q};
        end else begin
          alu_a_o = {1'b0, acc_q};
          alu_b_o = lo_q[0] ? {1'b0, op_q} : '0;
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Iteration step
  ////////////////////////////////////////////////////////////

  assign sum = alu_adder_ext_i[ex_pkg::XLEN+1:1];

  // The shifted remainder may carry a bit above the word, then it always fits
  assign div_ok = acc_q[ex_pkg::XLEN-1] | ~sum[ex_pkg::XLEN];

  always_comb begin
    if (is_div) begin
      acc_d = div_ok ? sum[ex_pkg::XLEN-1:0] : {acc_q[ex_pkg::XLEN-2:0], lo_q[ex_pkg::XLEN-1]};
      lo_d  = {lo_q[ex_pkg::XLEN-2:0], div_ok};
    end else begin
      acc_d = sum[ex_pkg::XLEN:1];
      lo_d  = {sum[0], lo_q[ex_pkg::XLEN-1:1]};
    end
  end

  // Sign fix and result pick
  always_comb begin
    case (md_req_i.op)
      ex_pkg::MD_DIV, ex_pkg::MD_DIVU: fix_mag = {{ex_pkg::XLEN{1'b0}}, lo_q};
      ex_pkg::MD_REM, ex_pkg::MD_REMU: fix_mag = {{ex_pkg::XLEN{1'b0}}, acc_q};
      default:                         fix_mag = {acc_q, lo_q};
    endcase
  end

  assign fix_val = neg_q ? -fix_mag : fix_mag;

  assign fix_result = (md_req_i.op inside {ex_pkg::MD_MULH, ex_pkg::MD_MULHSU,
                                           ex_pkg::MD_MULHU}) ?
                      fix_val[2*ex_pkg::XLEN-1:ex_pkg::XLEN] : fix_val[ex_pkg::XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::MD_IDLE: if (en_i) state_d = ex_pkg::MD_ABS;
      ex_pkg::MD_ABS:  state_d = (is_div && alu_is_equal_i) ? ex_pkg::MD_DONE : ex_pkg::MD_ITER;
      ex_pkg::MD_ITER: begin
        if (cnt_q == ex_pkg::md_cnt_t'(ex_pkg::MD_ITERATIONS - 1)) begin
          state_d = ex_pkg::MD_FIX;
        end
      end
      ex_pkg::MD_FIX:  state_d = ex_pkg::MD_DONE;
      default:         state_d = ex_pkg::MD_IDLE;
    endcase
    // Enable low always returns to idle
    if (!en_i) begin
      state_d = ex_pkg::MD_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ex_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= (state_q == ex_pkg::MD_ITER) ? ex_pkg::md_cnt_t'(cnt_q + 1'b1) : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      ex_pkg::MD_ABS: begin
        op_q   <= is_div ? abs_b : abs_a;
        lo_q   <= is_div ? abs_a : abs_b;
        acc_q  <= '0;
        neg_q  <= is_rem ? a_neg : (a_neg ^ b_neg);
        // Division by zero result, replaced in MD_FIX on the normal path
        result_q <= is_rem ? md_req_i.operand_a : '1;
      end
      ex_pkg::MD_ITER: begin
        acc_q <= acc_d;
        lo_q  <= lo_d;
      end
      ex_pkg::MD_FIX: result_q <= fix_result;
      default: ;
    endcase
  end

  assign valid_o  = (state_q == ex_pkg::MD_DONE);
  assign result_o = result_q;

endmodule

//--- logic/ex_alu.sv
/*
  Purely combinational ALU built around one 34-bit adder.
  While md_alu_sel_i is high the adder belongs to the multiply/divide unit, and
  result_o and the compare outputs are then meaningless for the request.
*/
`timescale 1ns/1ns

module ex_alu (
  input  ex_pkg::alu_req_t    alu_req_i,
  input  ex_pkg::md_operand_t md_alu_a_i,
  input  ex_pkg::md_operand_t md_alu_b_i,
  input  logic                md_alu_sel_i,
  output ex_pkg::xlen_word_t  adder_result_o,
  output ex_pkg::adder_ext_t  adder_result_ext_o,
  output ex_pkg::xlen_word_t  result_o,
  output logic                comparison_result_o,
  output logic                is_equal_o
);

  ex_pkg::xlen_word_t  op_a;
  ex_pkg::xlen_word_t  op_b;
  logic                negate;
  ex_pkg::adder_ext_t  operand_b_neg;
  ex_pkg::adder_ext_t  adder_in_a;
  ex_pkg::adder_ext_t  adder_in_b;
  logic                unsigned_lt;
  logic                signed_lt;
  logic [4:0]          shamt;
  ex_pkg::md_operand_t shift_in;
  ex_pkg::md_operand_t shift_right_ext;
  ex_pkg::xlen_word_t  shift_left;

  assign op_a = alu_req_i.operand_a;
  assign op_b = alu_req_i.operand_b;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Subtract and every compare go through a - b
  assign negate = alu_req_i.op inside {ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
                                       ex_pkg::ALU_EQ, ex_pkg::ALU_NE, ex_pkg::ALU_LT,
                                       ex_pkg::ALU_GE, ex_pkg::ALU_LTU, ex_pkg::ALU_GEU};

  // Bit 0 carries the +1 of the two's complement into the word
  assign operand_b_neg = {1'b0, op_b, 1'b0} ^ {(ex_pkg::XLEN + 2){negate}};

  // The unit marks a subtraction by setting the top bit of operand b,
  // which then also serves as its carry-in
  assign adder_in_a = md_alu_sel_i ? {md_alu_a_i, 1'b1} : {1'b0, op_a, 1'b1};
  assign adder_in_b = md_alu_sel_i ? {md_alu_b_i, md_alu_b_i[ex_pkg::XLEN]} : operand_b_neg;

  assign adder_result_ext_o = adder_in_a + adder_in_b;
  assign adder_result_o     = adder_result_ext_o[ex_pkg::XLEN:1];

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  assign is_equal_o = (adder_result_o == '0);

  // Top bit of the 33-bit difference is the unsigned borrow
  assign unsigned_lt = adder_result_ext_o[ex_pkg::XLEN+1];
  assign signed_lt   = (op_a[ex_pkg::XLEN-1] != op_b[ex_pkg::XLEN-1]) ?
                       op_a[ex_pkg::XLEN-1] : unsigned_lt;

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ALU_EQ:                 comparison_result_o = is_equal_o;
      ex_pkg::ALU_NE:                 comparison_result_o = ~is_equal_o;
      ex_pkg::ALU_LT, ex_pkg::ALU_SLT:   comparison_result_o = signed_lt;
      ex_pkg::ALU_GE:                 comparison_result_o = ~signed_lt;
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: comparison_result_o = unsigned_lt;
      ex_pkg::ALU_GEU:                comparison_result_o = ~unsigned_lt;
      default:                        comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shamt = op_b[4:0];

  // One extra bit on top replicates the sign for SRA
  assign shift_in        = {(alu_req_i.op == ex_pkg::ALU_SRA) & op_a[ex_pkg::XLEN-1], op_a};
  assign shift_right_ext = $signed(shift_in) >>> shamt;
  assign shift_left      = op_a << shamt;

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ALU_ADD, ex_pkg::ALU_SUB: result_o = adder_result_o;
      ex_pkg::ALU_XOR:                  result_o = op_a ^ op_b;
      ex_pkg::ALU_OR:                   result_o = op_a | op_b;
      ex_pkg::ALU_AND:                  result_o = op_a & op_b;
      ex_pkg::ALU_SLL:                  result_o = shift_left;
      ex_pkg::ALU_SRL, ex_pkg::ALU_SRA: result_o = shift_right_ext[ex_pkg::XLEN-1:0];
      // Set-less-than and the branch compares
      default: result_o = {{(ex_pkg::XLEN - 1){1'b0}}, comparison_result_o};
    endcase
  end

endmodule

//--- common/ex_pkg.sv
/*
  Widths, operation codes and request types of the RV32 execution stage.
  Enum encodings are local to this subsystem and do not follow the RISC-V opcode fields.
*/
package ex_pkg;

  localparam int unsigned XLEN           = 32;
  localparam int unsigned MD_ITERATIONS  = 32;
  // Enable to valid, worst case over all multiply/divide forms
  localparam int unsigned MD_MAX_LATENCY = 36;

  typedef logic [XLEN-1:0]                  xlen_word_t;
  typedef logic [XLEN+1:0]                  adder_ext_t;
  typedef logic [XLEN:0]                    md_operand_t;
  typedef logic [11:0]                      bt_imm_t;
  typedef logic [$clog2(MD_ITERATIONS)-1:0] md_cnt_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } md_op_e;

  typedef enum logic {
    JT_ALU, JT_BT
  } jt_sel_e;

  typedef enum logic [2:0] {
    MD_IDLE, MD_ABS, MD_ITER, MD_FIX, MD_DONE
  } md_state_e;

  typedef struct packed {
    alu_op_e    op;
    xlen_word_t operand_a;
    xlen_word_t operand_b;
  } alu_req_t;

  typedef struct packed {
    md_op_e     op;
    xlen_word_t operand_a;
    xlen_word_t operand_b;
  } md_req_t;

  typedef struct packed {
    jt_sel_e    jt_sel;
    bt_imm_t    imm;
    xlen_word_t pc;
  } bt_req_t;

endpackage
